// ==== rtl/cordic_pkg.sv ====
// CORDIC frequency shifter shared definitions
// Sample and phase widths, stage count, gain correction and arctangent table
package cordic_pkg;

  localparam int SAMPLE_WIDTH = 16;
  // Full circle is 2**PHASE_WIDTH
  localparam int PHASE_WIDTH = 24;
  // Stages after stage 0
  localparam int CORDIC_STAGES = 19;

  // atan(2**-i) in units of the folded 23-bit phase, quarter circle first
  localparam logic [PHASE_WIDTH-2:0] ATAN_TABLE [0:23] = '{
    23'd2097152, 23'd1238021, 23'd654136, 23'd332050,
    23'd166669,  23'd83416,   23'd41718,  23'd20860,
    23'd10430,   23'd5215,    23'd2608,   23'd1304,
    23'd652,     23'd326,     23'd163,    23'd81,
    23'd41,      23'd20,      23'd10,     23'd5,
    23'd3,       23'd1,       23'd1,      23'd0
  };

  // Inverse CORDIC gain, unsigned Q1.15 (about 0.6073)
  localparam logic [SAMPLE_WIDTH-1:0] GAIN_COMP = 16'd19899;
  localparam int GAIN_SHIFT = 15;

  // Accumulator, compensator, fold register and the stage chain
  localparam int PIPE_LATENCY = CORDIC_STAGES + 3;

endpackage

// ==== rtl/phase_accum.sv ====
// Phase accumulator
// Hands each strobed sample the running phase, then steps by freq
module phase_accum (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                enable,
  input  logic                                strobe_in,
  input  logic                                last_in,
  input  logic signed [cordic_pkg::PHASE_WIDTH-1:0] freq,
  output logic [cordic_pkg::PHASE_WIDTH-1:0]   phase,
  output logic                                phase_strobe,
  output logic                                phase_last
);

  logic [cordic_pkg::PHASE_WIDTH-1:0] acc;

  always_ff @(posedge clk) begin
    if (reset) begin
      acc          <= '0;
      phase        <= '0;
      phase_strobe <= 1'b0;
      phase_last   <= 1'b0;
    end else if (enable) begin
      phase_strobe <= strobe_in;
      if (strobe_in) begin
        phase      <= acc;
        phase_last <= last_in;
        // Restart the tone after the end of a packet
        if (last_in) begin
          acc <= '0;
        end else begin
          acc <= acc + freq;
        end
      end
    end
  end

endmodule

// ==== rtl/gain_comp.sv ====
// Gain compensator
// Scales I and Q by the inverse CORDIC gain ahead of the rotator
module gain_comp (
  input  logic                                        clk,
  input  logic                                        reset,
  input  logic                                        enable,
  input  logic                                        strobe_in,
  input  logic signed [cordic_pkg::SAMPLE_WIDTH-1:0]  i_in,
  input  logic signed [cordic_pkg::SAMPLE_WIDTH-1:0]  q_in,
  output logic signed [cordic_pkg::SAMPLE_WIDTH-1:0]  i_comp,
  output logic signed [cordic_pkg::SAMPLE_WIDTH-1:0]  q_comp
);

  logic signed [2*cordic_pkg::SAMPLE_WIDTH:0] i_prod;
  logic signed [2*cordic_pkg::SAMPLE_WIDTH:0] q_prod;

  // Gain is unsigned, so a zero is prepended before the signed multiply
  assign i_prod = i_in * $signed({1'b0, cordic_pkg::GAIN_COMP});
  assign q_prod = q_in * $signed({1'b0, cordic_pkg::GAIN_COMP});

  always_ff @(posedge clk) begin
    if (reset) begin
      i_comp <= '0;
      q_comp <= '0;
    end else if (enable && strobe_in) begin
      // Arithmetic shift by GAIN_SHIFT, truncated to the sample width
      i_comp <= i_prod[cordic_pkg::GAIN_SHIFT +: cordic_pkg::SAMPLE_WIDTH];
      q_comp <= q_prod[cordic_pkg::GAIN_SHIFT +: cordic_pkg::SAMPLE_WIDTH];
    end
  end

endmodule

// ==== rtl/cordic_stage.sv ====
// CORDIC micro-rotation stage
// Rotates by +/- atan(2**-SHIFT) depending on the sign of the residual angle
module cordic_stage #(
  parameter int DATA_WIDTH  = 18,
  parameter int ANGLE_WIDTH = 23,
  parameter int SHIFT       = 0
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          enable,
  input  logic                          strobe_in,
  input  logic                          last_in,
  input  logic signed [DATA_WIDTH-1:0]  xi,
  input  logic signed [DATA_WIDTH-1:0]  yi,
  input  logic [ANGLE_WIDTH-1:0]        zi,
  input  logic [ANGLE_WIDTH-1:0]        angle,
  output logic signed [DATA_WIDTH-1:0]  xo,
  output logic signed [DATA_WIDTH-1:0]  yo,
  output logic [ANGLE_WIDTH-1:0]        zo,
  output logic                          strobe_out,
  output logic                          last_out
);

  logic z_is_pos;

  assign z_is_pos = ~zi[ANGLE_WIDTH-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      strobe_out <= 1'b0;
      last_out   <= 1'b0;
      xo         <= '0;
      yo         <= '0;
      zo         <= '0;
    end else if (enable) begin
      strobe_out <= strobe_in;
      if (strobe_in) begin
        last_out <= last_in;
        xo <= z_is_pos ? xi - (yi >>> SHIFT) : xi + (yi >>> SHIFT);
        yo <= z_is_pos ? yi + (xi >>> SHIFT) : yi - (xi >>> SHIFT);
        zo <= z_is_pos ? zi - angle : zi + angle;
      end
    end
  end

endmodule

// ==== rtl/cordic_rotator.sv ====
// CORDIC rotator
// Folds the phase into +/- a quarter turn, then runs the stage chain
module cordic_rotator (
  input  logic                                        clk,
  input  logic                                        reset,
  input  logic                                        enable,
  input  logic                                        strobe_in,
  input  logic                                        last_in,
  input  logic signed [cordic_pkg::SAMPLE_WIDTH-1:0]  i_in,
  input  logic signed [cordic_pkg::SAMPLE_WIDTH-1:0]  q_in,
  input  logic [cordic_pkg::PHASE_WIDTH-1:0]          phase,
  output logic signed [cordic_pkg::SAMPLE_WIDTH-1:0]  i_out,
  output logic signed [cordic_pkg::SAMPLE_WIDTH-1:0]  q_out,
  output logic                                        strobe_out,
  output logic                                        last_out
);

  // Two guard bits for the CORDIC growth
  logic signed [cordic_pkg::SAMPLE_WIDTH+1:0] x [0:cordic_pkg::CORDIC_STAGES+1];
  logic signed [cordic_pkg::SAMPLE_WIDTH+1:0] y [0:cordic_pkg::CORDIC_STAGES+1];
  logic [cordic_pkg::PHASE_WIDTH-2:0]         z [0:cordic_pkg::CORDIC_STAGES+1];
  logic [cordic_pkg::CORDIC_STAGES+1:0]       strobe;
  logic [cordic_pkg::CORDIC_STAGES+1:0]       last;
  logic signed [cordic_pkg::SAMPLE_WIDTH+1:0] i_ext;
  logic signed [cordic_pkg::SAMPLE_WIDTH+1:0] q_ext;

  assign i_ext = {{2{i_in[cordic_pkg::SAMPLE_WIDTH-1]}}, i_in};
  assign q_ext = {{2{q_in[cordic_pkg::SAMPLE_WIDTH-1]}}, q_in};

  // Quadrant fold; quadrants 01 and 10 rotate by half a turn first
  always_ff @(posedge clk) begin
    if (reset) begin
      strobe[0] <= 1'b0;
      last[0]   <= 1'b0;
      x[0]      <= '0;
      y[0]      <= '0;
      z[0]      <= '0;
    end else if (enable) begin
      strobe[0] <= strobe_in;
      if (strobe_in) begin
        last[0] <= last_in;
        z[0]    <= phase[cordic_pkg::PHASE_WIDTH-2:0];
        case (phase[cordic_pkg::PHASE_WIDTH-1 -: 2])
          2'b01, 2'b10: begin
            x[0] <= -i_ext;
            y[0] <= -q_ext;
          end
          default: begin
            x[0] <= i_ext;
            y[0] <= q_ext;
          end
        endcase
      end
    end
  end

  for (genvar i = 0; i <= cordic_pkg::CORDIC_STAGES; i++) begin : g_stage
    cordic_stage #(
      .DATA_WIDTH  (cordic_pkg::SAMPLE_WIDTH + 2),
      .ANGLE_WIDTH (cordic_pkg::PHASE_WIDTH - 1),
      .SHIFT       (i)
    ) stage (
      .clk        (clk),
      .reset      (reset),
      .enable     (enable),
      .strobe_in  (strobe[i]),
      .last_in    (last[i]),
      .xi         (x[i]),
      .yi         (y[i]),
      .zi         (z[i]),
      .angle      (cordic_pkg::ATAN_TABLE[i]),
      .xo         (x[i+1]),
      .yo         (y[i+1]),
      .zo         (z[i+1]),
      .strobe_out (strobe[i+1]),
      .last_out   (last[i+1])
    );
  end

  // Drop the LSB and the top guard bit
  assign i_out      = x[cordic_pkg::CORDIC_STAGES+1][cordic_pkg::SAMPLE_WIDTH:1];
  assign q_out      = y[cordic_pkg::CORDIC_STAGES+1][cordic_pkg::SAMPLE_WIDTH:1];
  assign strobe_out = strobe[cordic_pkg::CORDIC_STAGES+1];
  assign last_out   = last[cordic_pkg::CORDIC_STAGES+1];

endmodule

// ==== rtl/freq_shifter.sv ====
// Frequency shifter top level
// Phase accumulator and gain compensator feeding a CORDIC rotator
module freq_shifter (
  input  logic                                        clk,
  input  logic                                        reset,
  input  logic                                        enable,
  input  logic                                        strobe_in,
  input  logic                                        last_in,
  input  logic signed [cordic_pkg::SAMPLE_WIDTH-1:0]  i_in,
  input  logic signed [cordic_pkg::SAMPLE_WIDTH-1:0]  q_in,
  input  logic signed [cordic_pkg::PHASE_WIDTH-1:0]   freq,
  output logic signed [cordic_pkg::SAMPLE_WIDTH-1:0]  i_out,
  output logic signed [cordic_pkg::SAMPLE_WIDTH-1:0]  q_out,
  output logic                                        strobe_out,
  output logic                                        last_out
);

  logic [cordic_pkg::PHASE_WIDTH-1:0]         phase;
  logic                                       phase_strobe;
  logic                                       phase_last;
  logic signed [cordic_pkg::SAMPLE_WIDTH-1:0] i_comp;
  logic signed [cordic_pkg::SAMPLE_WIDTH-1:0] q_comp;

  phase_accum accum (
    .clk          (clk),
    .reset        (reset),
    .enable       (enable),
    .strobe_in    (strobe_in),
    .last_in      (last_in),
    .freq         (freq),
    .phase        (phase),
    .phase_strobe (phase_strobe),
    .phase_last   (phase_last)
  );

  // Same latency as the accumulator, so phase and data line up
  gain_comp comp (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .strobe_in (strobe_in),
    .i_in      (i_in),
    .q_in      (q_in),
    .i_comp    (i_comp),
    .q_comp    (q_comp)
  );

  cordic_rotator rotator (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .strobe_in  (phase_strobe),
    .last_in    (phase_last),
    .i_in       (i_comp),
    .q_in       (q_comp),
    .phase      (phase),
    .i_out      (i_out),
    .q_out      (q_out),
    .strobe_out (strobe_out),
    .last_out   (last_out)
  );

endmodule

// ==== bench/freq_shifter_asserts.sv ====
// Frequency shifter protocol checks
// Quiet outputs after reset and frozen outputs while the pipeline is stalled
module freq_shifter_asserts (
  input logic                              clk,
  input logic                              reset,
  input logic                              enable,
  input logic                              strobe_in,
  input logic                              strobe_out,
  input logic                              last_out,
  input logic [cordic_pkg::SAMPLE_WIDTH-1:0] i_out,
  input logic [cordic_pkg::SAMPLE_WIDTH-1:0] q_out
);

  // Enabled cycles since the first accepted sample
  logic started;
  int   since;

  always @(posedge clk) begin
    if (reset) begin
      started <= 1'b0;
      since   <= 0;
    end else if (enable) begin
      if (!started && strobe_in) begin
        started <= 1'b1;
        since   <= 1;
      end else if (started && since < cordic_pkg::PIPE_LATENCY) begin
        since <= since + 1;
      end
    end
  end

  reset_clears: assert property (@(posedge clk) reset |=> !strobe_out && !last_out)
    else $error("strobe_out or last_out high after a reset cycle");

  no_early_output: assert property (@(posedge clk) disable iff (reset)
      (!started || since < cordic_pkg::PIPE_LATENCY) |-> !strobe_out && !last_out)
    else $error("Output strobe before the first sample could pass the pipeline");

  hold_on_stall: assert property (@(posedge clk) disable iff (reset)
      !enable |=> $stable(i_out) && $stable(q_out) && $stable(strobe_out) && $stable(last_out))
    else $error("Outputs changed while enable was low");

endmodule

bind freq_shifter freq_shifter_asserts asserts (
  .clk        (clk),
  .reset      (reset),
  .enable     (enable),
  .strobe_in  (strobe_in),
  .strobe_out (strobe_out),
  .last_out   (last_out),
  .i_out      (i_out),
  .q_out      (q_out)
);

// ==== bench/freq_shifter_tb.sv ====
// Frequency shifter testbench
// Directed and random sample streams checked against a bit-exact model
module freq_shifter_tb;

  localparam int SW = cordic_pkg::SAMPLE_WIDTH;
  localparam int PW = cordic_pkg::PHASE_WIDTH;
  localparam int LAT = cordic_pkg::PIPE_LATENCY;
  // Worst case per test, gaps and stalls included
  localparam int TEST_CYCLES = 1 + 64 + 64 + 128 * 4 + 6 * 8 * 2 + 128 * 9;
  localparam int NUM_TESTS = 6;
  localparam int TIMEOUT_CYCLES = 10 + TEST_CYCLES + (LAT + 2) * NUM_TESTS + 200;

  logic                 clk = 1'b0;
  logic                 reset;
  logic                 enable;
  logic                 strobe_in;
  logic                 last_in;
  logic signed [SW-1:0] i_in;
  logic signed [SW-1:0] q_in;
  logic signed [PW-1:0] freq;
  logic signed [SW-1:0] i_out;
  logic signed [SW-1:0] q_out;
  logic                 strobe_out;
  logic                 last_out;

  logic [31:0]          lcg_state = 32'hbb5fe583;
  logic [PW-1:0]        ref_acc;
  logic [2*SW-1:0]      exp_pair;
  logic signed [SW-1:0] exp_i [$];
  logic signed [SW-1:0] exp_q [$];
  logic                 exp_last [$];
  int                   exp_cycle [$];
  logic signed [SW-1:0] e_i;
  logic signed [SW-1:0] e_q;
  logic                 e_last;
  int                   e_cycle;
  int en_cycles = 0;
  int cycle_count = 0;
  int error_count = 0;
  int early_errors = 0;
  int sample_count = 0;
  int test_num = 0;
  int errors_before = 0;
  int samples_before = 0;
  int n;
  int k;
  int gap;
  int stall;

  freq_shifter uut (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .strobe_in  (strobe_in),
    .last_in    (last_in),
    .i_in       (i_in),
    .q_in       (q_in),
    .freq       (freq),
    .i_out      (i_out),
    .q_out      (q_out),
    .strobe_out (strobe_out),
    .last_out   (last_out)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Gain correction, quadrant fold, micro-rotations, then drop LSB and top guard bit
  function automatic logic [2*SW-1:0] rotate_ref(input logic signed [SW-1:0] si,
                                                 input logic signed [SW-1:0] sq,
                                                 input logic [PW-1:0] ph);
    int prod_i;
    int prod_q;
    int s;
    logic signed [SW-1:0] ic;
    logic signed [SW-1:0] qc;
    logic signed [SW+1:0] x;
    logic signed [SW+1:0] y;
    logic signed [SW+1:0] xn;
    logic signed [SW+1:0] yn;
    logic [PW-2:0] z;
    prod_i = int'(si) * int'(cordic_pkg::GAIN_COMP);
    prod_q = int'(sq) * int'(cordic_pkg::GAIN_COMP);
    ic = 16'(prod_i >>> cordic_pkg::GAIN_SHIFT);
    qc = 16'(prod_q >>> cordic_pkg::GAIN_SHIFT);
    x = 18'(ic);
    y = 18'(qc);
    if (ph[PW-1] != ph[PW-2]) begin
      x = -x;
      y = -y;
    end
    z = ph[PW-2:0];
    for (s = 0; s <= cordic_pkg::CORDIC_STAGES; s++) begin
      if (!z[PW-2]) begin
        xn = x - (y >>> s);
        yn = y + (x >>> s);
        z = z - cordic_pkg::ATAN_TABLE[s];
      end else begin
        xn = x + (y >>> s);
        yn = y - (x >>> s);
        z = z + cordic_pkg::ATAN_TABLE[s];
      end
      x = xn;
      y = yn;
    end
    return {x[SW:1], y[SW:1]};
  endfunction

  always @(posedge clk) begin
    if (!reset && enable) begin
      en_cycles <= en_cycles + 1;
    end
  end

  // Model each accepted sample, with its own copy of the phase accumulator
  always @(posedge clk) begin
    if (reset) begin
      ref_acc = '0;
    end else if (enable && strobe_in) begin
      exp_pair = rotate_ref(i_in, q_in, ref_acc);
      exp_i.push_back(exp_pair[2*SW-1:SW]);
      exp_q.push_back(exp_pair[SW-1:0]);
      exp_last.push_back(last_in);
      exp_cycle.push_back(en_cycles);
      if (last_in) begin
        ref_acc = '0;
      end else begin
        ref_acc = ref_acc + freq;
      end
    end
  end

  // A held output is consumed at the first enabled edge after it appears
  always @(posedge clk) begin
    if (!reset && enable && strobe_out) begin
      assert (exp_i.size() != 0) else begin
        $display("Output sample at time %0t with no sample expected", $time);
        error_count++;
      end
      if (exp_i.size() != 0) begin
        e_i = exp_i.pop_front();
        e_q = exp_q.pop_front();
        e_last = exp_last.pop_front();
        e_cycle = exp_cycle.pop_front();
        sample_count++;
        assert (i_out == e_i && q_out == e_q && last_out == e_last) else begin
          $display("Mismatch at time %0t: got i=%0d q=%0d last=%0b, expected i=%0d q=%0d last=%0b",
                   $time, i_out, q_out, last_out, e_i, e_q, e_last);
          error_count++;
        end
        assert (en_cycles - e_cycle == LAT) else begin
          $display("Mismatch at time %0t: latency %0d enabled cycles, expected %0d",
                   $time, en_cycles - e_cycle, LAT);
          error_count++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d samples still in flight",
               cycle_count, exp_i.size());
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic send_sample(input logic [SW-1:0] si, input logic [SW-1:0] sq, input logic sl);
    i_in = si;
    q_in = sq;
    last_in = sl;
    strobe_in = 1'b1;
    @(negedge clk);
    strobe_in = 1'b0;
    last_in = 1'b0;
  endtask

  // Sample waits with enable low, so the whole pipeline stalls
  task automatic send_stalled(input logic [SW-1:0] si, input logic [SW-1:0] sq, input logic sl,
                              input int cycles);
    i_in = si;
    q_in = sq;
    last_in = sl;
    strobe_in = 1'b1;
    enable = 1'b0;
    repeat (cycles) @(negedge clk);
    enable = 1'b1;
    @(negedge clk);
    strobe_in = 1'b0;
    last_in = 1'b0;
  endtask

  task automatic finish_test(input string name);
    while (exp_i.size() != 0) @(negedge clk);
    test_num++;
    $display("Test %0d %s: %0d samples checked, %0d errors", test_num, name,
             sample_count - samples_before, error_count + early_errors - errors_before);
    samples_before = sample_count;
    errors_before = error_count + early_errors;
  endtask

  initial begin
    reset = 1'b1;
    enable = 1'b1;
    strobe_in = 1'b0;
    last_in = 1'b0;
    i_in = '0;
    q_in = '0;
    freq = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    freq = 24'd1000;
    send_sample(16'd8000, -16'sd3000, 1'b1);
    for (k = 1; k < LAT; k++) begin
      assert (!strobe_out && !last_out) else begin
        $display("Output rose %0d cycles after the first sample at time %0t", k, $time);
        early_errors++;
      end
      @(negedge clk);
    end
    assert (strobe_out && last_out) else begin
      $display("First sample did not leave after %0d cycles at time %0t", LAT, $time);
      early_errors++;
    end
    finish_test("reset_latency");

    freq = '0;
    repeat (64) send_sample(16'(next_random()), 16'(next_random()), 1'b0);
    finish_test("zero_freq");

    freq = 24'd262144;
    repeat (64) send_sample(16'd20000, 16'd0, 1'b0);
    finish_test("tone");

    for (n = 0; n < 128; n++) begin
      freq = 24'(next_random());
      send_sample(16'(next_random()), 16'(next_random()), 1'b0);
      gap = int'(next_random() % 32'd4);
      repeat (gap) @(negedge clk);
    end
    finish_test("random_gaps");

    for (k = 0; k < 6; k++) begin
      freq = 24'(next_random());
      for (n = 0; n < 8; n++) begin
        send_sample(16'(next_random()), 16'(next_random()), n == 7);
      end
      gap = int'(next_random() % 32'd2);
      repeat (gap) @(negedge clk);
    end
    finish_test("packets");

    freq = 24'(next_random());
    for (n = 0; n < 128; n++) begin
      stall = 0;
      if (next_random() % 32'd3 == 32'd0) begin
        stall = int'(next_random() % 32'd8);
      end
      send_stalled(16'(next_random()), 16'(next_random()), n % 16 == 15, stall);
    end
    finish_test("stalls");

    $display("Summary: %0d tests, %0d samples checked, %0d errors",
             test_num, sample_count, error_count + early_errors);
    if (error_count + early_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
rtl/cordic_pkg.sv
rtl/phase_accum.sv
rtl/gain_comp.sv
rtl/cordic_stage.sv
rtl/cordic_rotator.sv
rtl/freq_shifter.sv
bench/freq_shifter_asserts.sv
bench/freq_shifter_tb.sv

// ==== Makefile ====
# Verilator build and run of the frequency shifter testbench

VERILATOR ?= verilator
TOP       ?= freq_shifter_tb
FLAGS     ?= --binary --timing --assert -j 0
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
PASS_TEXT ?= All tests passed

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the simulation output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
